// File: rtl/axis_pipe_cfg.svh
// ---------------------------------------------------------------------
// Build-time configuration of the AXI-Stream register pipeline
// Data width must be a whole number of bytes
// Ready reset policy names a value of axis_slice_pkg::ready_rst_e,
// so that package must be compiled before any user of the policy
// ---------------------------------------------------------------------

`ifndef AXIS_PIPE_CFG_SVH
`define AXIS_PIPE_CFG_SVH

// ---------------------------------------------------------------------
// Beat geometry
// ---------------------------------------------------------------------

// Width of tdata in bits
`define AXIS_DATA_W 32

// One keep bit per data byte
`define AXIS_KEEP_W (`AXIS_DATA_W / 8)

// ---------------------------------------------------------------------
// Reset behavior
// ---------------------------------------------------------------------

// Level of the registered input ready while reset is held
`define AXIS_READY_RST axis_slice_pkg::READY_LOW_IN_RST

`endif

// File: rtl/axis_slice_pkg.sv
// ---------------------------------------------------------------------
// Types that describe how a register slice behaves
// ---------------------------------------------------------------------

`default_nettype none

`include "axis_pipe_cfg.svh"

package axis_slice_pkg;

   // Input ready level while reset is held
   typedef enum logic {
      READY_LOW_IN_RST  = 1'b0,
      READY_HIGH_IN_RST = 1'b1
   } ready_rst_e;

   // Where the skid stage takes its next output beat from
   typedef enum logic {
      SRC_LIVE = 1'b0,
      SRC_SKID = 1'b1
   } src_sel_e;

endpackage

`default_nettype wire

// File: rtl/axis_beat_pkg.sv
// ---------------------------------------------------------------------
// Field types of one AXI-Stream beat
// Widths come from the pipeline configuration header
// ---------------------------------------------------------------------

`default_nettype none

`include "axis_pipe_cfg.svh"

package axis_beat_pkg;

   // ------------------------------------------------------------------
   // Payload fields
   // ------------------------------------------------------------------

   // One data word, byte 0 in the low bits
   typedef logic [`AXIS_DATA_W-1:0] data_t;

   // Byte qualifiers, bit n covers data byte n
   typedef logic [`AXIS_KEEP_W-1:0] keep_t;

   // The last flag travels as a plain logic bit

endpackage

`default_nettype wire

// File: rtl/axis_skid_stage.sv
// ---------------------------------------------------------------------
// Skid-buffer stage, input ready is a flop and reaches the source
// one cycle late; one beat of skid storage covers that cycle
// Registered outputs, latency one cycle when the output is free
// Skid register samples every cycle ready is high, idle cycles too
// ---------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "axis_pipe_cfg.svh"

module axis_skid_stage #(
   parameter axis_slice_pkg::ready_rst_e ready_rst = `AXIS_READY_RST
) (
   input  logic                  clk,
   input  logic                  rst_n,

   // Upstream side
   input  logic                  s_valid,
   input  axis_beat_pkg::data_t  s_data,
   input  axis_beat_pkg::keep_t  s_keep,
   input  logic                  s_last,
   output logic                  s_ready,

   // Downstream side
   output logic                  m_valid,
   output axis_beat_pkg::data_t  m_data,
   output axis_beat_pkg::keep_t  m_keep,
   output logic                  m_last,
   input  logic                  m_ready
);

   // Output register can take a new beat this cycle
   logic                      out_free;

   // Source select of the output mux
   axis_slice_pkg::src_sel_e  src_sel;

   // Skid register, one beat
   logic                      skid_valid;
   axis_beat_pkg::data_t      skid_data;
   axis_beat_pkg::keep_t      skid_keep;
   logic                      skid_last;

   // Beat picked for the output register
   logic                      sel_valid;
   axis_beat_pkg::data_t      sel_data;
   axis_beat_pkg::keep_t      sel_keep;
   logic                      sel_last;

   // ------------------------------------------------------------------
   // Registered ready
   // ------------------------------------------------------------------

   assign out_free = m_ready || !m_valid;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         s_ready <= (ready_rst == axis_slice_pkg::READY_HIGH_IN_RST);
      end else begin
         s_ready <= out_free;
      end
   end

   // ------------------------------------------------------------------
   // Source select
   // ------------------------------------------------------------------

   // With ready low in reset, the live input is not trusted on the
   // first cycle out of reset, since a held beat has not transferred yet.
   // With ready high in reset that cycle can already transfer,
   // so the live path is used from the start
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         if (ready_rst == axis_slice_pkg::READY_HIGH_IN_RST) begin
            src_sel <= axis_slice_pkg::SRC_LIVE;
         end else begin
            src_sel <= axis_slice_pkg::SRC_SKID;
         end
      end else if (out_free) begin
         src_sel <= axis_slice_pkg::SRC_LIVE;
      end else if (s_ready) begin
         // Output stalled while the source still saw ready high
         src_sel <= axis_slice_pkg::SRC_SKID;
      end
   end

   // ------------------------------------------------------------------
   // Skid register
   // ------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         skid_valid <= 1'b0;
      end else if (s_ready) begin
         skid_valid <= s_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (s_ready) begin
         skid_data <= s_data;
         skid_keep <= s_keep;
         skid_last <= s_last;
      end
   end

   always_comb begin
      if (src_sel == axis_slice_pkg::SRC_SKID) begin
         sel_valid = skid_valid;
         sel_data  = skid_data;
         sel_keep  = skid_keep;
         sel_last  = skid_last;
      end else begin
         sel_valid = s_valid;
         sel_data  = s_data;
         sel_keep  = s_keep;
         sel_last  = s_last;
      end
   end

   // ------------------------------------------------------------------
   // Output register
   // ------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         m_valid <= 1'b0;
      end else if (out_free) begin
         m_valid <= sel_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (out_free) begin
         m_data <= sel_data;
         m_keep <= sel_keep;
         m_last <= sel_last;
      end
   end

endmodule

`default_nettype wire

// File: rtl/axis_reg_stage.sv
// ---------------------------------------------------------------------
// Full register slice, cuts valid and data but not ready
// Input ready is combinational from m_ready
// One beat of storage, latency one cycle, full rate when m_ready holds
// ---------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "axis_pipe_cfg.svh"

module axis_reg_stage (
   input  logic                  clk,
   input  logic                  rst_n,

   // Upstream side
   input  logic                  s_valid,
   input  axis_beat_pkg::data_t  s_data,
   input  axis_beat_pkg::keep_t  s_keep,
   input  logic                  s_last,
   output logic                  s_ready,

   // Downstream side
   output logic                  m_valid,
   output axis_beat_pkg::data_t  m_data,
   output axis_beat_pkg::keep_t  m_keep,
   output logic                  m_last,
   input  logic                  m_ready
);

   // Register is empty or its beat leaves this cycle
   logic load;

   assign load    = !m_valid || m_ready;
   assign s_ready = load;

   // ------------------------------------------------------------------
   // Valid flag
   // ------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         m_valid <= 1'b0;
      end else if (load) begin
         m_valid <= s_valid;
      end
   end

   // ------------------------------------------------------------------
   // Beat payload
   // ------------------------------------------------------------------

   // Loads on idle cycles too, the contents only matter with m_valid
   always_ff @(posedge clk) begin
      if (load) begin
         m_data <= s_data;
         m_keep <= s_keep;
         m_last <= s_last;
      end
   end

endmodule

`default_nettype wire

// File: rtl/axis_pipe.sv
// ---------------------------------------------------------------------
// Two-stage AXI-Stream pipeline for long routes
// Skid stage first, so s_ready comes from a flop
// Register stage last, so m_valid and the beat come from flops
// Latency at least two cycles, one beat per cycle with a free sink
// ---------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "axis_pipe_cfg.svh"

module axis_pipe (
   input  logic                  clk,
   input  logic                  rst_n,

   // Stream in
   input  logic                  s_valid,
   input  axis_beat_pkg::data_t  s_data,
   input  axis_beat_pkg::keep_t  s_keep,
   input  logic                  s_last,
   output logic                  s_ready,

   // Stream out
   output logic                  m_valid,
   output axis_beat_pkg::data_t  m_data,
   output axis_beat_pkg::keep_t  m_keep,
   output logic                  m_last,
   input  logic                  m_ready
);

   // ------------------------------------------------------------------
   // Link between the two stages
   // ------------------------------------------------------------------

   logic                  mid_valid;
   axis_beat_pkg::data_t  mid_data;
   axis_beat_pkg::keep_t  mid_keep;
   logic                  mid_last;
   logic                  mid_ready;

   // ------------------------------------------------------------------
   // Stage 1, cuts the ready path
   // ------------------------------------------------------------------

   axis_skid_stage #(
      .ready_rst (`AXIS_READY_RST)
   ) skid_i (
      .clk     (clk),
      .rst_n   (rst_n),

      .s_valid (s_valid),
      .s_data  (s_data),
      .s_keep  (s_keep),
      .s_last  (s_last),
      .s_ready (s_ready),

      .m_valid (mid_valid),
      .m_data  (mid_data),
      .m_keep  (mid_keep),
      .m_last  (mid_last),
      .m_ready (mid_ready)
   );

   // ------------------------------------------------------------------
   // Stage 2, cuts the valid and data path
   // ------------------------------------------------------------------

   // Its combinational ready lands on the flop inside the skid stage
   axis_reg_stage reg_i (
      .clk     (clk),
      .rst_n   (rst_n),

      .s_valid (mid_valid),
      .s_data  (mid_data),
      .s_keep  (mid_keep),
      .s_last  (mid_last),
      .s_ready (mid_ready),

      .m_valid (m_valid),
      .m_data  (m_data),
      .m_keep  (m_keep),
      .m_last  (m_last),
      .m_ready (m_ready)
   );

endmodule

`default_nettype wire

// File: testbench/axis_pipe_sva.sv
// ----------------------------------------------------------------------
// Handshake assertions for the AXI-Stream pipeline bound to axis_pipe
// Skid-stage select, skid beat and skid output are reached through the bind
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "axis_pipe_cfg.svh"

module axis_pipe_sva (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      s_valid,
   input  axis_beat_pkg::data_t      s_data,
   input  axis_beat_pkg::keep_t      s_keep,
   input  logic                      s_last,
   input  logic                      s_ready,
   input  logic                      m_valid,
   input  axis_beat_pkg::data_t      m_data,
   input  axis_beat_pkg::keep_t      m_keep,
   input  logic                      m_last,
   input  logic                      m_ready,
   input  axis_slice_pkg::src_sel_e  src_sel,
   input  logic                      skid_valid,
   input  axis_beat_pkg::data_t      skid_data,
   input  axis_beat_pkg::keep_t      skid_keep,
   input  logic                      skid_last,
   input  logic                      skid_out_valid,
   input  axis_beat_pkg::data_t      skid_out_data,
   input  axis_beat_pkg::keep_t      skid_out_keep,
   input  logic                      skid_out_last
);

   // Output beat held while the sink stalls
   assert property (@(posedge clk) disable iff (!rst_n)
      m_valid && !m_ready |=> m_valid && $stable({m_data, m_keep, m_last}))
      else $error("output beat changed while stalled");

   // Source keeps its offered beat until it transfers
   assert property (@(posedge clk) disable iff (!rst_n)
      s_valid && !s_ready |=> s_valid && $stable({s_data, s_keep, s_last}))
      else $error("input beat changed while stalled");

   // First cycle out of reset
   assert property (@(posedge clk) $rose(rst_n) |-> !m_valid)
      else $error("m_valid high right after reset");

   // Back on the live input only once the skid beat sits in the output register
   assert property (@(posedge clk) disable iff (!rst_n)
      $past(src_sel) == axis_slice_pkg::SRC_SKID && $past(skid_valid)
         && src_sel == axis_slice_pkg::SRC_LIVE
      |-> skid_out_valid
         && {skid_out_data, skid_out_keep, skid_out_last}
            == $past({skid_data, skid_keep, skid_last}))
      else $error("skid register left with an unsent beat");

endmodule

bind axis_pipe axis_pipe_sva sva_i (
   .clk            (clk),
   .rst_n          (rst_n),
   .s_valid        (s_valid),
   .s_data         (s_data),
   .s_keep         (s_keep),
   .s_last         (s_last),
   .s_ready        (s_ready),
   .m_valid        (m_valid),
   .m_data         (m_data),
   .m_keep         (m_keep),
   .m_last         (m_last),
   .m_ready        (m_ready),
   .src_sel        (skid_i.src_sel),
   .skid_valid     (skid_i.skid_valid),
   .skid_data      (skid_i.skid_data),
   .skid_keep      (skid_i.skid_keep),
   .skid_last      (skid_i.skid_last),
   .skid_out_valid (skid_i.m_valid),
   .skid_out_data  (skid_i.m_data),
   .skid_out_keep  (skid_i.m_keep),
   .skid_out_last  (skid_i.m_last)
);

`default_nettype wire

// File: testbench/axis_pipe_tb.sv
// ----------------------------------------------------------------------
// Random beats for axis_pipe checked against a queue model
// Random sink back-pressure, throughput window and reset mid-stream
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "axis_pipe_cfg.svh"

module axis_pipe_tb;

   localparam int BEAT_W    = `AXIS_DATA_W + `AXIS_KEEP_W + 1;
   localparam int STEP_MAX  = 200;
   localparam int DRAIN_MAX = 2000;

   logic                  clk;
   logic                  rst_n;
   logic                  s_valid;
   axis_beat_pkg::data_t  s_data;
   axis_beat_pkg::keep_t  s_keep;
   logic                  s_last;
   logic                  s_ready;
   logic                  m_valid;
   axis_beat_pkg::data_t  m_data;
   axis_beat_pkg::keep_t  m_keep;
   logic                  m_last;
   logic                  m_ready;

   logic [BEAT_W-1:0]     model_q[$];
   logic                  sink_random;
   logic                  stall_prev;
   logic [BEAT_W-1:0]     stall_beat;
   string                 test_name;
   int                    errors;
   int                    checks;
   int                    delivered;
   int                    tests_run;
   int                    tests_failed;
   int                    errors_at_start;

   axis_pipe axis_pipe_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .s_valid (s_valid),
      .s_data  (s_data),
      .s_keep  (s_keep),
      .s_last  (s_last),
      .s_ready (s_ready),
      .m_valid (m_valid),
      .m_data  (m_data),
      .m_keep  (m_keep),
      .m_last  (m_last),
      .m_ready (m_ready)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Sink ready is either always high or a coin toss per cycle
   always @(posedge clk) begin
      if (sink_random) begin
         m_ready <= (($urandom % 2) == 0);
      end else begin
         m_ready <= 1'b1;
      end
   end

   // ---------------------------------------------------------------------
   // Monitor and model
   // ---------------------------------------------------------------------

   always @(posedge clk) begin
      logic [BEAT_W-1:0] out_beat;
      logic [BEAT_W-1:0] exp_beat;
      out_beat = {m_data, m_keep, m_last};
      if (!rst_n) begin
         stall_prev = 1'b0;
      end else begin
         if (s_valid && s_ready) begin
            model_q.push_back({s_data, s_keep, s_last});
         end
         if (stall_prev) begin
            checks++;
            assert (out_beat == stall_beat) else begin
               errors++;
               $display("CHECK FAILED %s stall hold: expected %h actual %h",
                        test_name, stall_beat, out_beat);
            end
         end
         if (m_valid && m_ready) begin
            delivered++;
            checks++;
            assert (model_q.size() != 0) else begin
               errors++;
               $display("%s: a beat came out that was never accepted", test_name);
            end
            if (model_q.size() != 0) begin
               exp_beat = model_q.pop_front();
               checks++;
               assert (out_beat == exp_beat) else begin
                  errors++;
                  $display("CHECK FAILED %s beat: expected %h actual %h",
                           test_name, exp_beat, out_beat);
               end
            end
         end
         stall_prev = m_valid && !m_ready;
         stall_beat = out_beat;
      end
   end

   // ---------------------------------------------------------------------
   // Helpers
   // ---------------------------------------------------------------------

   task automatic abort_on_timeout(input string what);
      $display("Timeout in %s while waiting for %s", test_name, what);
      $display("Test failed");
      $finish;
   endtask

   task automatic start_test(input string name);
      test_name       = name;
      errors_at_start = errors;
   endtask

   task automatic end_test();
      int n;
      n = errors - errors_at_start;
      tests_run++;
      if (n != 0) begin
         tests_failed++;
      end
      $display("%-16s %s (%0d errors)", test_name, (n == 0) ? "PASS" : "FAIL", n);
   endtask

   // Holds rst_n low for 8 cycles and checks the outputs meanwhile
   task automatic apply_reset();
      logic exp_ready;
      exp_ready = (`AXIS_READY_RST == axis_slice_pkg::READY_HIGH_IN_RST);
      rst_n   <= 1'b0;
      s_valid <= 1'b0;
      for (int i = 0; i < 8; i++) begin
         @(posedge clk);
         if (i >= 1) begin
            checks++;
            assert (!m_valid && s_ready == exp_ready) else begin
               errors++;
               $display("CHECK FAILED %s in reset: expected %b%b actual %b%b",
                        test_name, 1'b0, exp_ready, m_valid, s_ready);
            end
         end
         model_q.delete();
      end
      rst_n <= 1'b1;
      for (int i = 0; i < 2; i++) begin
         @(posedge clk);
         checks++;
         assert (!m_valid) else begin
            errors++;
            $display("CHECK FAILED %s after reset m_valid: expected 0 actual %b",
                     test_name, m_valid);
         end
         // Registered ready still shows the reset level in the first cycle
         if (i == 0) begin
            checks++;
            assert (s_ready == exp_ready) else begin
               errors++;
               $display("CHECK FAILED %s after reset s_ready: expected %b actual %b",
                        test_name, exp_ready, s_ready);
            end
         end
      end
   endtask

   // Offers n beats with idle_pct percent idle cycles and holds each until taken
   task automatic send_beats(input int n, input int idle_pct);
      int sent;
      int wait_cnt;
      sent     = 0;
      wait_cnt = 0;
      while (sent < n) begin
         @(posedge clk);
         if (s_valid && s_ready) begin
            sent++;
            wait_cnt = 0;
         end else begin
            wait_cnt++;
         end
         if (wait_cnt > STEP_MAX) begin
            abort_on_timeout("an input transfer");
         end
         if (!(s_valid && !s_ready)) begin
            if (sent < n && ($urandom % 100) >= idle_pct) begin
               s_valid <= 1'b1;
               s_data  <= $urandom;
               s_keep  <= axis_beat_pkg::keep_t'($urandom);
               s_last  <= (($urandom % 8) == 0);
            end else begin
               s_valid <= 1'b0;
            end
         end
      end
   endtask

   // Looks at the model on the falling edge, after the monitor has run
   task automatic wait_drain();
      int cnt;
      cnt = 0;
      do begin
         @(negedge clk);
         cnt++;
         if (cnt > DRAIN_MAX) begin
            abort_on_timeout("the pipeline to drain");
         end
      end while (model_q.size() != 0);
   endtask

   // ---------------------------------------------------------------------
   // Test sequence
   // ---------------------------------------------------------------------

   initial begin
      int d0;
      int got;
      void'($urandom(32'h9e83_f202));
      rst_n       = 1'b0;
      s_valid     = 1'b0;
      s_data      = '0;
      s_keep      = '0;
      s_last      = 1'b0;
      m_ready     = 1'b0;
      sink_random = 1'b0;
      stall_prev  = 1'b0;
      stall_beat  = '0;
      errors      = 0;
      checks      = 0;
      delivered   = 0;
      tests_run   = 0;
      tests_failed = 0;

      start_test("reset_state");
      apply_reset();
      end_test();

      start_test("free_sink");
      send_beats(200, 30);
      wait_drain();
      end_test();

      start_test("backpressure");
      sink_random = 1'b1;
      send_beats(400, 30);
      wait_drain();
      end_test();

      start_test("throughput");
      sink_random = 1'b0;
      got = 0;
      fork
         send_beats(100, 0);
         begin
            repeat (16) @(negedge clk);
            d0 = delivered;
            repeat (64) @(negedge clk);
            got = delivered - d0;
         end
      join
      wait_drain();
      checks++;
      assert (got >= 60) else begin
         errors++;
         $display("CHECK FAILED %s beats in 64 cycles: expected >= 60 actual %0d",
                  test_name, got);
      end
      end_test();

      start_test("reset_midstream");
      sink_random = 1'b1;
      send_beats(40, 20);
      apply_reset();
      send_beats(100, 30);
      wait_drain();
      end_test();

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: build.f
+incdir+rtl
rtl/axis_slice_pkg.sv
rtl/axis_beat_pkg.sv
rtl/axis_skid_stage.sv
rtl/axis_reg_stage.sv
rtl/axis_pipe.sv
testbench/axis_pipe_sva.sv
testbench/axis_pipe_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the axis_pipe testbench with Verilator.
# The run fails if the log holds the fail message or a step errors out.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module axis_pipe_tb \
   -o axis_pipe_sim > build.log 2>&1 \
   && ./obj_dir/axis_pipe_sim > "$LOG" 2>&1 \
   || { cat build.log "$LOG" 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat "$LOG"

grep -q "Test failed" "$LOG" \
   && { echo "Simulation FAILED"; exit 1; } \
   || { echo "Simulation PASSED"; exit 0; }
